// ==== l1_trigger_regs_top.f ====
design/trigger_bus_pkg.sv
design/l1_trigger_intercon.sv
design/trigger_reg_bank.sv
design/wb_return_merge.sv
design/l1_trigger_regs_top.sv
dv/l1_trigger_regs_tb.sv

// ==== Makefile ====
# Verilator build for the trigger register access path

TB_TOP = l1_trigger_regs_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f l1_trigger_regs_top.f --top-module l1_trigger_regs_top
	verilator --lint-only --timing -f l1_trigger_regs_top.f --top-module $(TB_TOP)

sim:
	verilator --binary --timing --assert -f l1_trigger_regs_top.f \
		--top-module $(TB_TOP) -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== dv/l1_trigger_regs_tb.sv ====
`timescale 1ns/1ps

// table driven testbench for the trigger register access path
module l1_trigger_regs_tb;

    localparam int WORDS     = 16;
    localparam int NUM_TESTS = 6;
    localparam int RAND_SEED = 32'h4203;

    typedef struct {
        logic                                   we;
        logic [trigger_bus_pkg::HOST_ADR_W-1:0] adr;
        logic [trigger_bus_pkg::DAT_W-1:0]      dat;
        logic                                   en;
        logic [trigger_bus_pkg::DAT_W-1:0]      exp_dat;
        bit                                     b2b;
        int                                     test;
    } entry_t;

    logic                                   wb_clk_i;
    logic                                   reset_i;
    logic                                   clock_enabled_i;
    logic                                   wb_cyc_i;
    logic                                   wb_we_i;
    logic [trigger_bus_pkg::HOST_ADR_W-1:0] wb_adr_i;
    logic [trigger_bus_pkg::DAT_W-1:0]      wb_dat_i;
    logic [trigger_bus_pkg::DAT_W-1:0]      wb_dat_o;
    logic                                   wb_ack_o;

    entry_t                                 stim_q[$];
    // expected register contents, follows every write in the table
    logic [trigger_bus_pkg::DAT_W-1:0]      model [trigger_bus_pkg::NUM_BANKS][WORDS];
    string                                  test_names [NUM_TESTS];
    int                                     cur_test;
    bit                                     b2b_mode;
    int                                     errors;
    int                                     checks;
    int                                     cycle_cnt;
    int                                     cycle_limit;

    l1_trigger_regs_top l1_trigger_regs_top_inst (
        .wb_clk_i        (wb_clk_i),
        .reset_i         (reset_i),
        .clock_enabled_i (clock_enabled_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_o        (wb_ack_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    // run limit scales with the table length
    always @(posedge wb_clk_i) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("TIMEOUT: the bus stopped acknowledging after %0d cycles", cycle_cnt);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [trigger_bus_pkg::HOST_ADR_W-1:0] make_adr(input int bank,
                                                                       input int word);
        logic [trigger_bus_pkg::HOST_ADR_W-1:0] adr;
        adr = '0;
        adr[trigger_bus_pkg::HOST_ADR_W-1 -: trigger_bus_pkg::BANK_SEL_W] =
            bank[trigger_bus_pkg::BANK_SEL_W-1:0];
        adr[trigger_bus_pkg::BANK_ADR_W-1:0] = word[trigger_bus_pkg::BANK_ADR_W-1:0];
        return adr;
    endfunction

    task automatic push_write(input int bank, input int word,
                              input logic [trigger_bus_pkg::DAT_W-1:0] data, input logic en);
        entry_t e;
        e.we      = 1'b1;
        e.adr     = make_adr(bank, word);
        e.dat     = data;
        e.en      = en;
        e.exp_dat = '0;
        e.b2b     = b2b_mode;
        e.test    = cur_test;
        // a disabled write or a word past the bank leaves the registers alone
        if (en && (word < WORDS)) begin
            model[bank][word] = data;
        end
        stim_q.push_back(e);
    endtask

    task automatic expect_read(input int bank, input int word, input logic en);
        entry_t e;
        e.we      = 1'b0;
        e.adr     = make_adr(bank, word);
        e.dat     = '0;
        e.en      = en;
        e.exp_dat = (en && (word < WORDS)) ? model[bank][word] : '0;
        e.b2b     = b2b_mode;
        e.test    = cur_test;
        stim_q.push_back(e);
    endtask

    // one Wishbone classic cycle, returns at the ack with cyc dropped
    task automatic bus_cycle(input entry_t e, output logic [trigger_bus_pkg::DAT_W-1:0] rdat);
        clock_enabled_i = e.en;
        wb_we_i         = e.we;
        wb_adr_i        = e.adr;
        wb_dat_i        = e.dat;
        wb_cyc_i        = 1'b1;
        do begin
            @(posedge wb_clk_i);
            #1;
        end while (!wb_ack_o);
        rdat     = wb_dat_o;
        wb_cyc_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic check_value(input logic [trigger_bus_pkg::DAT_W-1:0] actual,
                               input logic [trigger_bus_pkg::DAT_W-1:0] expected,
                               input string msg);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    initial begin
        logic [trigger_bus_pkg::DAT_W-1:0] iso_val [trigger_bus_pkg::NUM_BANKS];
        logic [trigger_bus_pkg::DAT_W-1:0] rdat;
        bit                                dup;
        int                                test_err_start;

        reset_i         = 1'b1;
        clock_enabled_i = 1'b1;
        wb_cyc_i        = 1'b0;
        wb_we_i         = 1'b0;
        wb_adr_i        = '0;
        wb_dat_i        = '0;
        errors          = 0;
        checks          = 0;
        cycle_cnt       = 0;
        cycle_limit     = 1000;
        void'($urandom(RAND_SEED));
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            for (int w = 0; w < WORDS; w++) begin
                model[b][w] = '0;
            end
        end
        test_names = '{"reset values", "write read", "isolation", "out of range",
                       "clock disabled", "back to back"};

        cur_test = 0;
        b2b_mode = 1'b0;
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            expect_read(b, 0, 1'b1);
        end
        cur_test = 1;
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            push_write(b, 3, 32'hA500_0000 | {17'd0, make_adr(b, 3)}, 1'b1);
            expect_read(b, 3, 1'b1);
        end
        // same local word in every bank, each value different
        cur_test = 2;
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            do begin
                iso_val[b] = $urandom;
                dup        = 1'b0;
                for (int p = 0; p < b; p++) begin
                    if (iso_val[p] == iso_val[b]) begin
                        dup = 1'b1;
                    end
                end
            end while (dup);
            push_write(b, 5, iso_val[b], 1'b1);
        end
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            expect_read(b, 5, 1'b1);
        end
        cur_test = 3;
        push_write(1, 0, 32'h0C0F_FEE0, 1'b1);
        push_write(1, 15, 32'h0000_F00F, 1'b1);
        push_write(1, WORDS, 32'hFFFF_FFFF, 1'b1);
        push_write(1, 13'h1FFF, 32'h5A5A_5A5A, 1'b1);
        expect_read(1, WORDS, 1'b1);
        expect_read(1, 13'h1FFF, 1'b1);
        for (int w = 0; w < WORDS; w++) begin
            expect_read(1, w, 1'b1);
        end
        cur_test = 4;
        push_write(2, 7, 32'h1234_5678, 1'b1);
        push_write(2, 7, 32'hDEAD_BEEF, 1'b0);
        expect_read(2, 7, 1'b0);
        expect_read(2, 7, 1'b1);
        cur_test = 5;
        b2b_mode = 1'b1;
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            push_write(b, 9, 32'h9900_0000 | {17'd0, make_adr(b, 9)}, 1'b1);
        end
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            expect_read(b, 9, 1'b1);
        end

        cycle_limit = stim_q.size() * 12 + 100;

        repeat (3) @(posedge wb_clk_i);
        #1;
        reset_i = 1'b0;

        test_err_start = 0;
        for (int i = 0; i < stim_q.size(); i++) begin
            if (!stim_q[i].b2b) begin
                @(posedge wb_clk_i);
                #1;
            end
            bus_cycle(stim_q[i], rdat);
            if (!stim_q[i].we) begin
                check_value(rdat, stim_q[i].exp_dat,
                            $sformatf("%s read of %h", test_names[stim_q[i].test],
                                      stim_q[i].adr));
            end
            if ((i == stim_q.size() - 1) || (stim_q[i+1].test != stim_q[i].test)) begin
                if (errors == test_err_start) begin
                    $display("test %0d %s: ok", stim_q[i].test, test_names[stim_q[i].test]);
                end else begin
                    $display("test %0d %s: failed with %0d errors", stim_q[i].test,
                             test_names[stim_q[i].test], errors - test_err_start);
                end
                test_err_start = errors;
            end
        end

        $display("tests %0d, checks %0d, errors %0d", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== design/l1_trigger_regs_top.sv ====
`timescale 1ns/1ps

// trigger register access path
// host port -> intercon -> four register banks -> return merge -> intercon
module l1_trigger_regs_top #(
    parameter int BANK_WORDS = 16,
    parameter int ACK_DELAY  = 1
) (
    input  logic                                    wb_clk_i,
    input  logic                                    reset_i,
    input  logic                                    clock_enabled_i,
    input  logic                                    wb_cyc_i,
    input  logic                                    wb_we_i,
    input  logic [trigger_bus_pkg::HOST_ADR_W-1:0]  wb_adr_i,
    input  logic [trigger_bus_pkg::DAT_W-1:0]       wb_dat_i,
    output logic [trigger_bus_pkg::DAT_W-1:0]       wb_dat_o,
    output logic                                    wb_ack_o
);

    logic [trigger_bus_pkg::NUM_BANKS-1:0]                                  bank_cyc;
    logic [trigger_bus_pkg::NUM_BANKS-1:0]                                  bank_we;
    logic [trigger_bus_pkg::NUM_BANKS-1:0]                                  bank_ack;
    logic [trigger_bus_pkg::NUM_BANKS-1:0][trigger_bus_pkg::BANK_ADR_W-1:0] bank_adr;
    logic [trigger_bus_pkg::NUM_BANKS-1:0][trigger_bus_pkg::DAT_W-1:0]      bank_wdat;
    logic [trigger_bus_pkg::NUM_BANKS-1:0][trigger_bus_pkg::DAT_W-1:0]      bank_rdat;
    logic [trigger_bus_pkg::DAT_W-1:0]                                      rsp_dat;
    logic                                                                   rsp_ack;
    logic                                                                   dis_ack;

    l1_trigger_intercon intercon_inst (
        .wb_clk_i        (wb_clk_i),
        .reset_i         (reset_i),
        .clock_enabled_i (clock_enabled_i),
        .wb_cyc_i        (wb_cyc_i),
        .wb_we_i         (wb_we_i),
        .wb_adr_i        (wb_adr_i),
        .wb_dat_i        (wb_dat_i),
        .wb_dat_o        (wb_dat_o),
        .wb_ack_o        (wb_ack_o),
        .bank_cyc_o      (bank_cyc),
        .bank_we_o       (bank_we),
        .bank_adr_o      (bank_adr),
        .bank_dat_o      (bank_wdat),
        .bank_ack_i      (bank_ack),
        .rsp_dat_i       (rsp_dat),
        .rsp_ack_i       (rsp_ack),
        .dis_ack_o       (dis_ack)
    );

    // thresh, control, agc and biquad banks in select code order
    for (genvar i = 0; i < trigger_bus_pkg::NUM_BANKS; i++) begin : g_bank
        localparam trigger_bus_pkg::bank_id_e BANK_ID = trigger_bus_pkg::bank_id_e'(i);

        trigger_reg_bank #(
            .BANK_WORDS (BANK_WORDS),
            .ACK_DELAY  (ACK_DELAY)
        ) bank_inst (
            .wb_clk_i (wb_clk_i),
            .reset_i  (reset_i),
            .cyc_i    (bank_cyc[BANK_ID]),
            .we_i     (bank_we[BANK_ID]),
            .adr_i    (bank_adr[BANK_ID]),
            .dat_i    (bank_wdat[BANK_ID]),
            .ack_o    (bank_ack[BANK_ID]),
            .dat_o    (bank_rdat[BANK_ID])
        );
    end

    wb_return_merge merge_inst (
        .wb_clk_i   (wb_clk_i),
        .reset_i    (reset_i),
        .bank_ack_i (bank_ack),
        .bank_dat_i (bank_rdat),
        .dis_ack_i  (dis_ack),
        .rsp_ack_o  (rsp_ack),
        .rsp_dat_o  (rsp_dat)
    );

endmodule

// ==== design/wb_return_merge.sv ====
`timescale 1ns/1ps

// registered return path from the banks back to the intercon
// banks drive zero outside their ack so an OR is enough
module wb_return_merge (
    input  logic                                    wb_clk_i,
    input  logic                                    reset_i,
    input  logic [trigger_bus_pkg::NUM_BANKS-1:0]   bank_ack_i,
    input  logic [trigger_bus_pkg::NUM_BANKS-1:0][trigger_bus_pkg::DAT_W-1:0] bank_dat_i,
    input  logic                                    dis_ack_i,
    output logic                                    rsp_ack_o,
    output logic [trigger_bus_pkg::DAT_W-1:0]       rsp_dat_o
);

    logic [trigger_bus_pkg::DAT_W-1:0] or_dat;

    always_comb begin
        or_dat = '0;
        for (int b = 0; b < trigger_bus_pkg::NUM_BANKS; b++) begin
            or_dat = or_dat | bank_dat_i[b];
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            rsp_ack_o <= 1'b0;
        end else begin
            rsp_ack_o <= (|bank_ack_i) || dis_ack_i;
        end
    end

    // disabled answer returns zero since no bank is in its ack cycle
    always_ff @(posedge wb_clk_i) begin
        rsp_dat_o <= or_dat;
    end

    // the OR only works with a single responder per cycle
    a_single_responder: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        $onehot0({bank_ack_i, dis_ack_i})
    );

endmodule

// ==== design/trigger_reg_bank.sv ====
`timescale 1ns/1ps

// one bank of trigger registers behind a Wishbone target port
// ack comes ACK_DELAY cycles after cyc_i rises
module trigger_reg_bank #(
    parameter int BANK_WORDS = 16,
    parameter int ACK_DELAY  = 1
) (
    input  logic                                    wb_clk_i,
    input  logic                                    reset_i,
    input  logic                                    cyc_i,
    input  logic                                    we_i,
    input  logic [trigger_bus_pkg::BANK_ADR_W-1:0]  adr_i,
    input  logic [trigger_bus_pkg::DAT_W-1:0]       dat_i,
    output logic                                    ack_o,
    output logic [trigger_bus_pkg::DAT_W-1:0]       dat_o
);

    localparam int IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;
    localparam int CNT_W = (ACK_DELAY > 1) ? $clog2(ACK_DELAY) : 1;

    logic [trigger_bus_pkg::DAT_W-1:0]  regs [BANK_WORDS];
    logic [CNT_W-1:0]                   delay_cnt;
    logic                               done;
    logic                               fire;
    logic                               in_range;
    logic [IDX_W-1:0]                   idx;

    // words past the implemented range read zero and ignore writes
    assign in_range = (32'(adr_i) < BANK_WORDS);
    assign idx      = adr_i[IDX_W-1:0];

    // done keeps the ack from repeating while cyc_i falls
    assign fire = cyc_i && !done && (delay_cnt == CNT_W'(ACK_DELAY - 1));

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            delay_cnt <= '0;
            done      <= 1'b0;
            ack_o     <= 1'b0;
            dat_o     <= '0;
        end else begin
            ack_o <= fire;
            // data is zero except in the ack cycle so the merge can simply OR
            dat_o <= '0;
            if (!cyc_i) begin
                delay_cnt <= '0;
                done      <= 1'b0;
            end else if (fire) begin
                done <= 1'b1;
                if (!we_i && in_range) begin
                    dat_o <= regs[idx];
                end
            end else if (!done) begin
                delay_cnt <= delay_cnt + 1'b1;
            end
        end
    end

    // trigger settings come up cleared
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            for (int w = 0; w < BANK_WORDS; w++) begin
                regs[w] <= '0;
            end
        end else if (fire && we_i && in_range) begin
            regs[idx] <= dat_i;
        end
    end

    // the intercon must keep the cycle up through the ack
    a_ack_in_cyc: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        ack_o |-> cyc_i
    );

endmodule

// ==== design/l1_trigger_intercon.sv ====
`timescale 1ns/1ps

// registered host side of the trigger register path
// top address bits pick the bank, the low bits go to that bank as its local address
module l1_trigger_intercon (
    input  logic                                        wb_clk_i,
    input  logic                                        reset_i,
    input  logic                                        clock_enabled_i,
    // host port
    input  logic                                        wb_cyc_i,
    input  logic                                        wb_we_i,
    input  logic [trigger_bus_pkg::HOST_ADR_W-1:0]      wb_adr_i,
    input  logic [trigger_bus_pkg::DAT_W-1:0]           wb_dat_i,
    output logic [trigger_bus_pkg::DAT_W-1:0]           wb_dat_o,
    output logic                                        wb_ack_o,
    // per bank request lines
    output logic [trigger_bus_pkg::NUM_BANKS-1:0]       bank_cyc_o,
    output logic [trigger_bus_pkg::NUM_BANKS-1:0]       bank_we_o,
    output logic [trigger_bus_pkg::NUM_BANKS-1:0][trigger_bus_pkg::BANK_ADR_W-1:0] bank_adr_o,
    output logic [trigger_bus_pkg::NUM_BANKS-1:0][trigger_bus_pkg::DAT_W-1:0]      bank_dat_o,
    input  logic [trigger_bus_pkg::NUM_BANKS-1:0]       bank_ack_i,
    // merged return path
    input  logic [trigger_bus_pkg::DAT_W-1:0]           rsp_dat_i,
    input  logic                                        rsp_ack_i,
    output logic                                        dis_ack_o
);

    typedef enum logic [1:0] {
        IDLE        = 2'd0,
        TRANSACTION = 2'd1,
        WAIT_ACK    = 2'd2,
        FINISH      = 2'd3
    } state_e;

    state_e                     state;
    trigger_bus_pkg::bank_id_e  bank_sel;
    logic                       enabled;
    logic                       start;

    // a new host cycle is only taken from IDLE
    assign start = (state == IDLE) && wb_cyc_i;

    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (wb_cyc_i) begin
                        state <= TRANSACTION;
                    end
                end
                TRANSACTION: begin
                    state <= WAIT_ACK;
                end
                WAIT_ACK: begin
                    // covers both a bank ack and the disabled answer
                    if (rsp_ack_i) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // bank select and enable are frozen for the whole transaction
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            bank_sel <= trigger_bus_pkg::BANK_THRESH;
            enabled  <= 1'b0;
        end else if (start) begin
            bank_sel <= trigger_bus_pkg::bank_id_e'(
                wb_adr_i[trigger_bus_pkg::HOST_ADR_W-1 -: trigger_bus_pkg::BANK_SEL_W]);
            enabled  <= clock_enabled_i;
        end
    end

    // cycle line stays up until the bank acks
    always_ff @(posedge wb_clk_i) begin
        if (reset_i) begin
            bank_cyc_o <= '0;
            dis_ack_o  <= 1'b0;
        end else begin
            // with the bank clock stopped nothing downstream is touched
            dis_ack_o <= (state == TRANSACTION) && !enabled;
            for (int i = 0; i < trigger_bus_pkg::NUM_BANKS; i++) begin
                if (bank_ack_i[i]) begin
                    bank_cyc_o[i] <= 1'b0;
                end else if ((state == TRANSACTION) && enabled && (int'(bank_sel) == i)) begin
                    bank_cyc_o[i] <= 1'b1;
                end
            end
        end
    end

    // request payload only moves toward the selected bank
    always_ff @(posedge wb_clk_i) begin
        if ((state == TRANSACTION) && enabled) begin
            bank_we_o[bank_sel]  <= wb_we_i;
            bank_adr_o[bank_sel] <= wb_adr_i[trigger_bus_pkg::BANK_ADR_W-1:0];
            bank_dat_o[bank_sel] <= wb_dat_i;
        end
    end

    // merged data is only valid for one cycle so hold it for the host ack
    always_ff @(posedge wb_clk_i) begin
        if ((state == WAIT_ACK) && rsp_ack_i) begin
            wb_dat_o <= rsp_dat_i;
        end
    end

    assign wb_ack_o = (state == FINISH);

    // only one bank may be addressed at a time
    a_one_bank_cyc: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        $onehot0(bank_cyc_o)
    );

    // host ack is a single cycle pulse
    a_ack_pulse: assert property (
        @(posedge wb_clk_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o
    );

endmodule

// ==== design/trigger_bus_pkg.sv ====
// shared widths and bank names for the trigger register access path
package trigger_bus_pkg;

    // host word address splits into bank select on top and local address below
    localparam int BANK_SEL_W = 2;
    localparam int BANK_ADR_W = 13;
    localparam int HOST_ADR_W = BANK_SEL_W + BANK_ADR_W;

    // all banks carry the same 32 bit payload
    localparam int DAT_W = 32;

    // one bank per select code
    localparam int NUM_BANKS = 1 << BANK_SEL_W;

    // bank select codes as seen in wb_adr_i[14:13]
    //   0x0000 - 0x1FFF thresholds and scaler control
    //   0x2000 - 0x3FFF trigger control (beam masks)
    //   0x4000 - 0x5FFF AGC
    //   0x6000 - 0x7FFF biquad filters
    typedef enum logic [BANK_SEL_W-1:0] {
        BANK_THRESH  = 2'd0,
        BANK_CONTROL = 2'd1,
        BANK_AGC     = 2'd2,
        BANK_BQ      = 2'd3
    } bank_id_e;

endpackage
